/* vlog.f */
design/dqs_io_pkg.sv
design/ddr_out_if.sv
design/write_path.sv
design/strobe_gen.sv
design/read_capture.sv
design/dqs_io_top.sv
dv/dqs_io_properties.sv
dv/dqs_io_checker.sv
dv/tb_top.sv

/* Makefile */
# Verilator build and run for the DQ/DQS group

LOG = sim.log

.PHONY: all lint clean

all: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "simulation stopped before a verdict"; exit 1; }

obj_dir/Vtb_top: vlog.f design/*.sv dv/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module tb_top

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module dqs_io_top

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_top.sv */
// DQ/DQS group testbench

`timescale 1ns/1ps

module tb_top;

	localparam int RESET_CYCLES = 8;
	localparam int PHASE_CYCLES = 200;
	localparam int NUM_PHASES = 4;
	localparam int BEAT_BITS = dqs_io_pkg::WORDS_PER_BEAT * dqs_io_pkg::PIN_WIDTH;
	// 808 cycles of stimulus and a margin of 192 cycles
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + 192;

	logic hr_clock_in;
	logic reset_n_write_strobe_clock_in;
	dqs_io_pkg::beat_t write_data_in, dq_in, read_data_out;
	logic write_oe_in, output_strobe_ena, capture_strobe_ena, dqs_in_rise, dqs_in_fall;
	dqs_io_pkg::pin_word_t dq_rise, dq_fall;
	logic dq_oe, dqs_rise, dqs_fall, dqs_oe, read_valid;
	int phase, check_count, error_count;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'h3fbd47ae;

	dqs_io_top #(.PREAMBLE(dqs_io_pkg::PREAMBLE_LOW)) u_dut (.*);
	dqs_io_checker #(.PREAMBLE(dqs_io_pkg::PREAMBLE_LOW)) u_checker (.*);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// one stimulus cycle in which each test only moves its own inputs
	task automatic drive_cycle(input int test);
		logic [31:0] ctrl;
		logic [31:0] wr;
		logic [31:0] rd;
		@(posedge hr_clock_in);
		#2;
		ctrl = lcg_step(lcg_state);
		wr = lcg_step(ctrl);
		rd = lcg_step(wr);
		lcg_state = rd;
		if (test == 1 || test == 4)
		begin
			write_data_in = wr[31 -: BEAT_BITS];
			write_oe_in = ctrl[31];
		end
		// enables toggle rarely, which gives bursts of several cycles
		if ((test == 2 || test == 4) && ctrl[30:28] == 3'd0)
			output_strobe_ena = !output_strobe_ena;
		if (test >= 3)
		begin
			if (ctrl[27:25] == 3'd0)
				capture_strobe_ena = !capture_strobe_ena;
			// a rising strobe never shows up in two cycles in a row
			dqs_in_rise = ctrl[24] && !dqs_in_rise;
			dqs_in_fall = ctrl[23];
			dq_in = rd[31 -: BEAT_BITS];
		end
	endtask

	initial
	begin
		hr_clock_in = 1'b0;
		forever #20 hr_clock_in = ~hr_clock_in;
	end

	always @(posedge hr_clock_in)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		reset_n_write_strobe_clock_in = 1'b0;
		write_data_in = '0;
		write_oe_in = 1'b0;
		output_strobe_ena = 1'b0;
		dq_in = '0;
		dqs_in_rise = 1'b0;
		dqs_in_fall = 1'b0;
		capture_strobe_ena = 1'b0;
		phase = 0;
		repeat (RESET_CYCLES) @(posedge hr_clock_in);
		#2;
		reset_n_write_strobe_clock_in = 1'b1;
		for (int test = 1; test <= NUM_PHASES; test++)
		begin
			phase = test;
			repeat (PHASE_CYCLES) drive_cycle(test);
		end
		// the checker still needs the last outputs and closes the final test
		@(posedge hr_clock_in);
		#2;
		phase = NUM_PHASES + 1;
		repeat (2) @(posedge hr_clock_in);
		$display("summary: %0d checks, %0d check errors, %0d assertion failures",
			check_count, error_count, u_dut.u_properties.failure_count);
		if (error_count == 0 && u_dut.u_properties.failure_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* dv/dqs_io_checker.sv */
// DQ/DQS group checker

`timescale 1ns/1ps

module dqs_io_checker #(
	parameter dqs_io_pkg::preamble_e PREAMBLE = dqs_io_pkg::PREAMBLE_LOW
) (
	input  logic                  hr_clock_in,
	input  logic                  reset_n_write_strobe_clock_in,
	input  int                    phase,
	input  dqs_io_pkg::beat_t     write_data_in, dq_in, read_data_out,
	input  logic                  write_oe_in, output_strobe_ena, capture_strobe_ena,
	input  logic                  dqs_in_rise, dqs_in_fall,
	input  dqs_io_pkg::pin_word_t dq_rise, dq_fall,
	input  logic                  dq_oe, dqs_rise, dqs_fall, dqs_oe, read_valid,
	output int                    check_count,
	output int                    error_count
);

	string test_names[5] = '{"reset", "write path", "low preamble", "read gating", "read data"};
	int test_checks = 0;
	int test_errors = 0;
	int current = 0;

	// expected outputs for the cycle after the last sample
	dqs_io_pkg::beat_t exp_write = '0;
	dqs_io_pkg::beat_t exp_rdata = '0;
	logic exp_dq_oe = 1'b0;
	logic exp_dqs_rise = 1'b0;
	logic exp_dqs_oe = 1'b0;
	logic exp_valid = 1'b0;
	logic prev_ena = 1'b0;
	dqs_io_pkg::gate_state_e gate = dqs_io_pkg::GATE_CLOSED;

	task automatic compare(input string name, input dqs_io_pkg::beat_t actual,
		input dqs_io_pkg::beat_t expected);
		test_checks++;
		check_count++;
		if (actual !== expected)
		begin
			test_errors++;
			error_count++;
			$display("CHECK FAILED time %0t: %s is %h, expected %h",
				$time, name, actual, expected);
		end
	endtask

	initial
	begin
		check_count = 0;
		error_count = 0;
	end

	// outputs settle after the rising edge, so the falling edge is a quiet place to look
	always @(negedge hr_clock_in)
	begin
		if (phase != current)
		begin
			$display("test %0d %s: %0d checks, %0d errors", current, test_names[current],
				test_checks, test_errors);
			test_checks = 0;
			test_errors = 0;
			current = phase;
		end
		compare("dq_rise", 16'(dq_rise), 16'(exp_write[0]));
		compare("dq_fall", 16'(dq_fall), 16'(exp_write[1]));
		compare("dq_oe", 16'(dq_oe), 16'(exp_dq_oe));
		compare("dqs_rise", 16'(dqs_rise), 16'(exp_dqs_rise));
		compare("dqs_fall", 16'(dqs_fall), '0);
		compare("dqs_oe", 16'(dqs_oe), 16'(exp_dqs_oe));
		compare("read_valid", 16'(read_valid), 16'(exp_valid));
		compare("read_data_out", read_data_out, exp_rdata);
		if (!reset_n_write_strobe_clock_in)
		begin
			exp_write = '0;
			exp_rdata = '0;
			exp_dq_oe = 1'b0;
			exp_dqs_rise = 1'b0;
			exp_dqs_oe = 1'b0;
			exp_valid = 1'b0;
			prev_ena = 1'b0;
			gate = dqs_io_pkg::GATE_CLOSED;
		end
		else
		begin
			exp_write = write_data_in;
			exp_dq_oe = write_oe_in;
			exp_dqs_oe = output_strobe_ena;
			// low preamble keeps the strobe quiet in the first enabled cycle of a burst
			if (PREAMBLE == dqs_io_pkg::PREAMBLE_HIGH)
				exp_dqs_rise = output_strobe_ena;
			else if (PREAMBLE == dqs_io_pkg::PREAMBLE_LOW)
				exp_dqs_rise = output_strobe_ena && prev_ena;
			else
				exp_dqs_rise = 1'b1;
			prev_ena = output_strobe_ena;
			exp_valid = (gate == dqs_io_pkg::GATE_OPEN) && dqs_in_rise;
			if (exp_valid)
				exp_rdata = dq_in;
			// the gate outlives the enable until a cycle with the falling strobe low
			if (gate == dqs_io_pkg::GATE_CLOSED && capture_strobe_ena)
				gate = dqs_io_pkg::GATE_OPEN;
			else if (gate == dqs_io_pkg::GATE_OPEN && !capture_strobe_ena && !dqs_in_fall)
				gate = dqs_io_pkg::GATE_CLOSED;
		end
	end

endmodule

/* dv/dqs_io_properties.sv */
// DQ/DQS group assertions

`timescale 1ns/1ps

module dqs_io_properties (
	input logic hr_clock_in,
	input logic reset_n_write_strobe_clock_in,
	input logic dq_oe, dqs_rise, dqs_fall, dqs_oe, read_valid
);

	// number of assertion failures so far
	int failure_count = 0;

	// each capture is a single-cycle pulse
	valid_single_pulse: assert property (@(posedge hr_clock_in)
		disable iff (!reset_n_write_strobe_clock_in) read_valid |=> !read_valid)
	else
	begin
		failure_count++;
		$error("read_valid stayed high for two cycles");
	end

	strobe_fall_low: assert property (@(posedge hr_clock_in) dqs_fall == 1'b0)
	else
	begin
		failure_count++;
		$error("dqs_fall went high");
	end

	// no enable, strobe or capture while the group is held in reset
	quiet_in_reset: assert property (@(posedge hr_clock_in)
		!reset_n_write_strobe_clock_in |-> !dq_oe && !dqs_oe && !dqs_rise && !read_valid)
	else
	begin
		failure_count++;
		$error("an output was active during reset");
	end

endmodule

bind dqs_io_top dqs_io_properties u_properties (
	.hr_clock_in                   (hr_clock_in),
	.reset_n_write_strobe_clock_in (reset_n_write_strobe_clock_in),
	.dq_oe                         (dq_oe),
	.dqs_rise                      (dqs_rise),
	.dqs_fall                      (dqs_fall),
	.dqs_oe                        (dqs_oe),
	.read_valid                    (read_valid)
);

/* design/dqs_io_top.sv */
// DQ/DQS I/O group top level

`timescale 1ns/1ps

module dqs_io_top #(
	parameter dqs_io_pkg::preamble_e PREAMBLE = dqs_io_pkg::PREAMBLE_NONE
) (
	input  logic                  hr_clock_in,
	input  logic                  reset_n_write_strobe_clock_in,

	// write side
	input  dqs_io_pkg::beat_t     write_data_in,
	input  logic                  write_oe_in,
	input  logic                  output_strobe_ena,

	// read side
	input  dqs_io_pkg::beat_t     dq_in,
	input  logic                  dqs_in_rise,
	input  logic                  dqs_in_fall,
	input  logic                  capture_strobe_ena,

	// outgoing pin pairs
	output dqs_io_pkg::pin_word_t dq_rise,
	output dqs_io_pkg::pin_word_t dq_fall,
	output logic                  dq_oe,
	output logic                  dqs_rise,
	output logic                  dqs_fall,
	output logic                  dqs_oe,

	// captured read data
	output dqs_io_pkg::beat_t     read_data_out,
	output logic                  read_valid
);

	ddr_out_if u_out_if ();

	write_path u_write_path (
		.hr_clock_in                   (hr_clock_in),
		.reset_n_write_strobe_clock_in (reset_n_write_strobe_clock_in),
		.write_data_in                 (write_data_in),
		.write_oe_in                   (write_oe_in),
		.pins                          (u_out_if.data_src)
	);

	strobe_gen #(
		.PREAMBLE (PREAMBLE)
	) u_strobe_gen (
		.hr_clock_in                   (hr_clock_in),
		.reset_n_write_strobe_clock_in (reset_n_write_strobe_clock_in),
		.output_strobe_ena             (output_strobe_ena),
		.pins                          (u_out_if.strobe_src)
	);

	read_capture u_read_capture (
		.hr_clock_in                   (hr_clock_in),
		.reset_n_write_strobe_clock_in (reset_n_write_strobe_clock_in),
		.dq_in                         (dq_in),
		.dqs_in_rise                   (dqs_in_rise),
		.dqs_in_fall                   (dqs_in_fall),
		.capture_strobe_ena            (capture_strobe_ena),
		.read_data_out                 (read_data_out),
		.read_valid                    (read_valid)
	);

	// pin pairs leave the group as plain ports
	assign dq_rise  = u_out_if.dq_rise;
	assign dq_fall  = u_out_if.dq_fall;
	assign dq_oe    = u_out_if.dq_oe;
	assign dqs_rise = u_out_if.dqs_rise;
	assign dqs_fall = u_out_if.dqs_fall;
	assign dqs_oe   = u_out_if.dqs_oe;

endmodule

/* design/read_capture.sv */
// DQS gated read capture

`timescale 1ns/1ps

module read_capture (
	input  logic              hr_clock_in,
	input  logic              reset_n_write_strobe_clock_in,
	input  dqs_io_pkg::beat_t dq_in,
	input  logic              dqs_in_rise,
	input  logic              dqs_in_fall,
	input  logic              capture_strobe_ena,
	output dqs_io_pkg::beat_t read_data_out,
	output logic              read_valid
);

	dqs_io_pkg::gate_state_e gate_state;
	dqs_io_pkg::gate_state_e gate_next;

	logic capture_hit;

	// the gate opens on the enable and only drops on a low falling strobe,
	// so a strobe pulse in flight is never cut in half
	always_comb
	begin
		gate_next = gate_state;
		case (gate_state)
			dqs_io_pkg::GATE_CLOSED:
			begin
				if (capture_strobe_ena)
					gate_next = dqs_io_pkg::GATE_OPEN;
			end
			dqs_io_pkg::GATE_OPEN:
			begin
				if (!capture_strobe_ena && !dqs_in_fall)
					gate_next = dqs_io_pkg::GATE_CLOSED;
			end
			default:
			begin
				gate_next = dqs_io_pkg::GATE_CLOSED;
			end
		endcase
	end

	assign capture_hit = (gate_state == dqs_io_pkg::GATE_OPEN) && dqs_in_rise;

	always_ff @(posedge hr_clock_in or negedge reset_n_write_strobe_clock_in)
	begin
		if (!reset_n_write_strobe_clock_in)
		begin
			gate_state <= dqs_io_pkg::GATE_CLOSED;
			read_valid <= 1'b0;
		end
		else
		begin
			gate_state <= gate_next;
			read_valid <= capture_hit;
		end
	end

	// captured pair holds until the next gated rising strobe
	always_ff @(posedge hr_clock_in or negedge reset_n_write_strobe_clock_in)
	begin
		if (!reset_n_write_strobe_clock_in)
		begin
			read_data_out <= '0;
		end
		else if (capture_hit)
		begin
			read_data_out[0] <= dq_in[0];
			read_data_out[1] <= dq_in[1];
		end
	end

endmodule

/* design/strobe_gen.sv */
// DQS output strobe generator

`timescale 1ns/1ps

module strobe_gen #(
	parameter dqs_io_pkg::preamble_e PREAMBLE = dqs_io_pkg::PREAMBLE_NONE
) (
	input  logic          hr_clock_in,
	input  logic          reset_n_write_strobe_clock_in,
	input  logic          output_strobe_ena,
	ddr_out_if.strobe_src pins
);

	// enable of the previous cycle, doubles as the registered strobe enable
	logic ena_q;

	// registered rise half of the strobe
	logic rise_q;
	logic rise_next;

	always_comb
	begin
		case (PREAMBLE)
			dqs_io_pkg::PREAMBLE_HIGH:
			begin
				// strobe toggles from the first enabled cycle
				rise_next = output_strobe_ena;
			end
			dqs_io_pkg::PREAMBLE_LOW:
			begin
				// first enabled cycle stays low and forms the preamble
				rise_next = output_strobe_ena & ena_q;
			end
			default:
			begin
				// free-running strobe, held low only while in reset
				rise_next = 1'b1;
			end
		endcase
	end

	always_ff @(posedge hr_clock_in or negedge reset_n_write_strobe_clock_in)
	begin
		if (!reset_n_write_strobe_clock_in)
		begin
			ena_q  <= 1'b0;
			rise_q <= 1'b0;
		end
		else
		begin
			ena_q  <= output_strobe_ena;
			rise_q <= rise_next;
		end
	end

	assign pins.dqs_rise = rise_q;

	// the falling half of every strobe cycle is low
	assign pins.dqs_fall = 1'b0;

	assign pins.dqs_oe = ena_q;

endmodule

/* design/write_path.sv */
// DQ write output registers

`timescale 1ns/1ps

module write_path (
	input  logic              hr_clock_in,
	input  logic              reset_n_write_strobe_clock_in,
	input  dqs_io_pkg::beat_t write_data_in,
	input  logic              write_oe_in,
	ddr_out_if.data_src       pins
);

	dqs_io_pkg::pin_word_t data_rise_q;
	dqs_io_pkg::pin_word_t data_fall_q;
	logic                  oe_q;

	// full-rate output stage, word 0 goes out on the rising half
	always_ff @(posedge hr_clock_in or negedge reset_n_write_strobe_clock_in)
	begin
		if (!reset_n_write_strobe_clock_in)
		begin
			data_rise_q <= '0;
			data_fall_q <= '0;
			oe_q        <= 1'b0;
		end
		else
		begin
			data_rise_q <= write_data_in[0];
			data_fall_q <= write_data_in[1];
			oe_q        <= write_oe_in;
		end
	end

	// pins only drive while the enable is high
	assign pins.dq_rise = data_rise_q;
	assign pins.dq_fall = data_fall_q;
	assign pins.dq_oe   = oe_q;

endmodule

/* design/ddr_out_if.sv */
// Outgoing DDR pin pairs

`timescale 1ns/1ps

interface ddr_out_if;

	// data pins as a rise/fall pair with an active-high enable
	dqs_io_pkg::pin_word_t dq_rise;
	dqs_io_pkg::pin_word_t dq_fall;
	logic                  dq_oe;

	// strobe pin as a rise/fall pair with its own enable
	logic                  dqs_rise;
	logic                  dqs_fall;
	logic                  dqs_oe;

	modport data_src (
		output dq_rise,
		output dq_fall,
		output dq_oe
	);

	modport strobe_src (
		output dqs_rise,
		output dqs_fall,
		output dqs_oe
	);

	modport pins (
		input dq_rise,
		input dq_fall,
		input dq_oe,
		input dqs_rise,
		input dqs_fall,
		input dqs_oe
	);

endinterface

/* design/dqs_io_pkg.sv */
// DQ/DQS group definitions

package dqs_io_pkg;

	// data pins in one DQ group
	localparam int PIN_WIDTH = 8;

	// one rise word and one fall word per hr_clock_in cycle
	localparam int WORDS_PER_BEAT = 2;

	typedef logic [PIN_WIDTH-1:0] pin_word_t;

	// word 0 is the rise word, word 1 is the fall word
	typedef logic [WORDS_PER_BEAT-1:0][PIN_WIDTH-1:0] beat_t;

	// strobe behaviour before the first enabled cycle of a burst
	typedef enum logic [1:0] {
		PREAMBLE_NONE = 2'd0,
		PREAMBLE_LOW  = 2'd1,
		PREAMBLE_HIGH = 2'd2
	} preamble_e;

	// read capture window
	typedef enum logic {
		GATE_CLOSED = 1'b0,
		GATE_OPEN   = 1'b1
	} gate_state_e;

endpackage
